// File: arbMux.f
hdl/arbPkg.sv
hdl/inputQueue.sv
hdl/roundRobinArbiter.sv
hdl/outputStage.sv
hdl/arbMux.sv
dv/arbMuxTb.sv

// File: dv/arbMuxTb.sv
module arbMuxTb;
   timeunit 1ns;
   timeprecision 1ps;
   import arbPkg::*;

   localparam int seedInit     = 32'h798e;
   localparam int waitLimit    = 400;
   localparam int stallWindow  = 30;
   localparam int satCycles    = 60;
   localparam int randomCycles = 300;

   // Downstream credit modes
   localparam int modePrompt   = 0;
   localparam int modeWithhold = 1;
   localparam int modeRandom   = 2;

   logic                   clock;
   logic                   reset;
   logic [portCount - 1:0] inValid;
   dataWord                inData [portCount];
   logic                   outCredit;
   logic [portCount - 1:0] inCredit;
   logic                   outValid;
   dataWord                outData;
   portIndex               outPort;

   integer  seed;
   int      cycle;
   int      errorCount;
   int      testsPassed;
   int      testsFailed;

   // Upstream credit bookkeeping per port
   int      sent [portCount];
   int      returned [portCount];
   int      seqNum [portCount];

   // Per-port expected words
   dataWord scoreboard [portCount][$];

   // Output side state kept by the checker
   int      outCount;
   int      outPerPort [portCount];
   int      lastOutCycle;
   int      owed;
   int      modelPrev;
   int      rotationChecks;

   int      creditMode;
   int      releaseBudget;
   logic    rotationCheck;
   logic    creditCoin;

   arbMux arbMux_inst (
      .clock     (clock),
      .reset     (reset),
      .inValid   (inValid),
      .inData    (inData),
      .outCredit (outCredit),
      .inCredit  (inCredit),
      .outValid  (outValid),
      .outData   (outData),
      .outPort   (outPort)
   );

   // 8 ns clock
   initial clock = 1'b0;
   always #4 clock = ~clock;

   always @(posedge clock) cycle <= cycle + 1;

   // Expected winner of the rotation or -1 with no request
   function automatic int nextPort(input int prevPort, input logic [3:0] reqSet);
      int start;
      int cand;
      int pick;
      pick = -1;
      if (prevPort < 0) start = 3;
      else start = (prevPort + 3) % 4;
      // Walk downward with wrap, previous winner comes last
      for (int i = 0; i < 4; i++) begin
         cand = (start - i + 4) % 4;
         if (pick < 0 && reqSet[cand]) pick = cand;
      end
      return pick;
   endfunction

   // Upstream credit counts at the edge that completes the pop
   // Coin for the random downstream credit mode
   always @(posedge clock or negedge reset) begin
      if (!reset) begin
         for (int p = 0; p < portCount; p++) begin
            returned[p] = 0;
         end
      end
      else begin
         for (int p = 0; p < portCount; p++) begin
            if (inCredit[p]) begin
               returned[p]++;
            end
         end
         if (creditMode == modeRandom) begin
            creditCoin = 1'($random(seed));
         end
      end
   end

   // Checker and downstream credit model on the falling edge
   always @(negedge clock) begin
      int expPort;
      dataWord expData;
      if (!reset) begin
         outCount = 0;
         owed = 0;
         modelPrev = -1;
         outCredit <= 1'b0;
         for (int p = 0; p < portCount; p++) begin
            outPerPort[p] = 0;
         end
      end
      else begin
         if (outValid) begin
            outCount++;
            outPerPort[outPort]++;
            lastOutCycle = cycle;
            owed++;
            if (rotationCheck) begin
               expPort = nextPort(modelPrev, 4'b1111);
               rotationChecks++;
               assert (int'(outPort) == expPort) else begin
                  $display("Fail time=%0t outPort expected %0d actual %0d",
                     $time, expPort, outPort);
                  errorCount++;
               end
            end
            modelPrev = int'(outPort);
            assert (scoreboard[outPort].size() != 0) else begin
               $display("Error at %0t: word %h on port %0d was never sent",
                  $time, outData, outPort);
               errorCount++;
            end
            if (scoreboard[outPort].size() != 0) begin
               expData = scoreboard[outPort].pop_front();
               assert (outData == expData) else begin
                  $display("Fail time=%0t outData expected %h actual %h",
                     $time, expData, outData);
                  errorCount++;
               end
            end
         end
         // Return downstream credit per mode
         outCredit <= 1'b0;
         if (owed > 0) begin
            if (creditMode == modePrompt ||
                (creditMode == modeRandom && creditCoin) ||
                (creditMode == modeWithhold && releaseBudget > 0)) begin
               outCredit <= 1'b1;
               owed--;
               if (creditMode == modeWithhold) releaseBudget--;
            end
         end
      end
   end

   // One negedge of stimulus
   // A port sends only while it holds credit
   task automatic driveCycle(input logic [3:0] want);
      int avail;
      @(negedge clock);
      for (int p = 0; p < portCount; p++) begin
         avail = queueDepth - sent[p] + returned[p];
         assert (avail >= 0 && avail <= queueDepth) else begin
            $display("Error at %0t: port %0d credit out of range (%0d)", $time, p, avail);
            errorCount++;
         end
         inValid[p] = 1'b0;
         if (want[p] && avail > 0) begin
            inValid[p] = 1'b1;
            inData[p] = dataWord'((p << 12) | (seqNum[p] & 12'hfff));
            scoreboard[p].push_back(inData[p]);
            seqNum[p]++;
            sent[p]++;
         end
      end
   endtask

   task automatic resetDut();
      @(negedge clock);
      reset = 1'b0;
      inValid = '0;
      for (int p = 0; p < portCount; p++) begin
         sent[p] = 0;
         scoreboard[p].delete();
      end
      repeat (4) @(negedge clock);
      reset = 1'b1;
   endtask

   // Idle inputs until every scoreboard empties
   task automatic drain();
      int guard;
      int pending;
      guard = 0;
      pending = 1;
      while (pending != 0 && guard < waitLimit) begin
         driveCycle(4'b0000);
         guard++;
         pending = 0;
         for (int p = 0; p < portCount; p++) pending += scoreboard[p].size();
      end
      if (pending != 0) begin
         $display("Error at %0t: timeout with %0d words still undelivered", $time, pending);
         errorCount++;
      end
      repeat (4) driveCycle(4'b0000);
   endtask

   task automatic checkCreditReturn();
      for (int p = 0; p < portCount; p++) begin
         assert (returned[p] == outPerPort[p]) else begin
            $display("Fail time=%0t inCredit[%0d] count expected %0d actual %0d",
               $time, p, outPerPort[p], returned[p]);
            errorCount++;
         end
      end
   endtask

   task automatic finishTest(input string name, input int errorsBefore);
      if (errorCount == errorsBefore) begin
         testsPassed++;
         $display("test %s: ok", name);
      end
      else begin
         testsFailed++;
         $display("test %s: %0d errors", name, errorCount - errorsBefore);
      end
   endtask

   initial begin
      int errs;
      int startCycle;
      int base;
      int guard;
      seed = seedInit;
      reset = 1'b0;
      inValid = '0;
      outCredit = 1'b0;
      cycle = 0;
      errorCount = 0;
      testsPassed = 0;
      testsFailed = 0;
      creditMode = modePrompt;
      releaseBudget = 0;
      rotationCheck = 1'b0;
      rotationChecks = 0;
      creditCoin = 1'b0;
      for (int p = 0; p < portCount; p++) begin
         inData[p] = '0;
         seqNum[p] = 0;
      end
      resetDut();

      // Single port pass-through with latency check
      errs = errorCount;
      driveCycle(4'b0010);
      startCycle = cycle;
      guard = 0;
      while (outCount == 0 && guard < waitLimit) begin
         driveCycle(4'b0000);
         guard++;
      end
      if (outCount == 0) begin
         $display("Error at %0t: timeout waiting for first word", $time);
         errorCount++;
      end
      assert (lastOutCycle - startCycle == 2) else begin
         $display("Fail time=%0t latency expected 2 actual %0d",
            $time, lastOutCycle - startCycle);
         errorCount++;
      end
      repeat (10) driveCycle(4'b0010);
      drain();
      assert (outPerPort[1] == outCount) else begin
         $display("Fail time=%0t outPerPort[1] expected %0d actual %0d",
            $time, outCount, outPerPort[1]);
         errorCount++;
      end
      finishTest("1 single port", errs);

      // Saturation from reset with rotation 3 2 1 0
      errs = errorCount;
      resetDut();
      rotationCheck = 1'b1;
      repeat (satCycles) driveCycle(4'b1111);
      rotationCheck = 1'b0;
      drain();
      assert (rotationChecks >= satCycles / 2) else begin
         $display("Error at %0t: only %0d rotation checks made", $time, rotationChecks);
         errorCount++;
      end
      finishTest("2 round robin", errs);

      // Downstream credit stall and single releases
      errs = errorCount;
      creditMode = modeWithhold;
      base = outCount;
      repeat (2) driveCycle(4'b1111);
      repeat (stallWindow) driveCycle(4'b0000);
      assert (outCount - base == creditMax) else begin
         $display("Fail time=%0t outValid count expected %0d actual %0d",
            $time, creditMax, outCount - base);
         errorCount++;
      end
      for (int i = 1; i <= 4; i++) begin
         releaseBudget = 1;
         repeat (12) driveCycle(4'b0000);
         assert (outCount - base == creditMax + i) else begin
            $display("Fail time=%0t outValid count expected %0d actual %0d",
               $time, creditMax + i, outCount - base);
            errorCount++;
         end
      end
      creditMode = modePrompt;
      drain();
      finishTest("3 credit stall", errs);

      // Upstream credits match delivered words
      errs = errorCount;
      checkCreditReturn();
      finishTest("4 upstream credit", errs);

      // Random traffic with random downstream credit
      errs = errorCount;
      creditMode = modeRandom;
      repeat (randomCycles) driveCycle(4'($random(seed)));
      creditMode = modePrompt;
      drain();
      checkCreditReturn();
      finishTest("5 random traffic", errs);

      $display("tests passed %0d, failed %0d, errors %0d", testsPassed, testsFailed, errorCount);
      if (errorCount == 0 && testsFailed == 0) begin
         $display("TB PASSED");
      end
      else begin
         $display("TB FAILED");
      end
      $finish;
   end

endmodule

// File: hdl/arbMux.sv
module arbMux (
   input  logic                           clock,
   input  logic                           reset,
   input  logic [arbPkg::portCount - 1:0] inValid,
   input  arbPkg::dataWord                inData [arbPkg::portCount],
   input  logic                           outCredit,
   output logic [arbPkg::portCount - 1:0] inCredit,
   output logic                           outValid,
   output arbPkg::dataWord                outData,
   output arbPkg::portIndex               outPort
);
   import arbPkg::*;

   // Queue status, doubles as the request vector
   logic [portCount - 1:0] notEmpty;

   // One-hot grant, also the pop of each queue
   logic [portCount - 1:0] grant;

   // Head of each queue toward the output mux
   dataWord                headData [portCount];

   // Output stage out of downstream credit
   logic                   holdArbitration;

   // One input queue per source port
   for (genvar p = 0; p < portCount; p++) begin : queueGen
      inputQueue inputQueue_inst (
         .clock    (clock),
         .reset    (reset),
         .inValid  (inValid[p]),
         .inData   (inData[p]),
         .pop      (grant[p]),
         .notEmpty (notEmpty[p]),
         .headData (headData[p]),
         .inCredit (inCredit[p])
      );
   end

   // Picks one non-empty queue per cycle
   roundRobinArbiter roundRobinArbiter_inst (
      .clock           (clock),
      .reset           (reset),
      .holdArbitration (holdArbitration),
      .req             (notEmpty),
      .grant           (grant)
   );

   // Registers the granted word and tracks downstream credit
   outputStage outputStage_inst (
      .clock           (clock),
      .reset           (reset),
      .grant           (grant),
      .headData        (headData),
      .outCredit       (outCredit),
      .holdArbitration (holdArbitration),
      .outValid        (outValid),
      .outData         (outData),
      .outPort         (outPort)
   );

endmodule

// File: hdl/arbPkg.sv
package arbPkg;

   // Number of request ports, the arbiter rotation is fixed at four
   localparam int portCount = 4;

   // Width of one transaction word
   localparam int dataWidth = 16;

   // Entries per input queue
   // Also the upstream credit each source holds after reset
   localparam int queueDepth = 4;

   // Downstream credits after reset and ceiling of the credit counter
   localparam int creditMax = 4;

   // One transaction word
   typedef logic [dataWidth - 1:0] dataWord;

   // Source port number carried with each downstream word
   typedef logic [1:0] portIndex;

endpackage

// File: hdl/inputQueue.sv
module inputQueue (
   input  logic            clock,
   input  logic            reset,
   input  logic            inValid,
   input  arbPkg::dataWord inData,
   input  logic            pop,
   output logic            notEmpty,
   output arbPkg::dataWord headData,
   output logic            inCredit
);
   import arbPkg::*;

   typedef logic [$clog2(queueDepth) - 1:0] ptrType;
   typedef logic [$clog2(queueDepth + 1) - 1:0] countType;

   // Circular buffer storage
   dataWord  entries [queueDepth];

   ptrType   wrPtr;
   ptrType   rdPtr;
   countType count;

   logic     full;
   logic     popDone;

   // Pointer advance with wrap at the last entry
   function automatic ptrType nextPtr(input ptrType ptr);
      ptrType result;
      if (ptr == ptrType'(queueDepth - 1)) begin
         result = '0;
      end
      else begin
         result = ptr + 1'b1;
      end
      return result;
   endfunction

   assign notEmpty = (count != '0);
   assign full     = (count == countType'(queueDepth));

   // Head entry is visible as soon as it is written
   assign headData = entries[rdPtr];

   // Only a pop that really removes an entry counts
   assign popDone  = pop && notEmpty;

   // One credit back to the source per removed entry, same cycle as the pop
   assign inCredit = popDone;

   // Write port
   always_ff @(posedge clock) begin
      if (inValid) begin
         entries[wrPtr] <= inData;
      end
   end

   // Pointers and occupancy
   always_ff @(posedge clock or negedge reset) begin
      if (!reset) begin
         wrPtr <= '0;
         rdPtr <= '0;
         count <= '0;
      end
      else begin
         if (inValid) begin
            wrPtr <= nextPtr(wrPtr);
         end
         if (popDone) begin
            rdPtr <= nextPtr(rdPtr);
         end
         // Push and pop together leave the count unchanged
         case ({inValid, popDone})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

   // Source must hold credit, so a full queue never sees a write
   pushNotFull: assert property (
      @(posedge clock) disable iff (!reset)
      inValid |-> !full
   ) else $error("inputQueue: write while full");

   // Arbiter grants only non-empty queues
   popNotEmpty: assert property (
      @(posedge clock) disable iff (!reset)
      pop |-> notEmpty
   ) else $error("inputQueue: pop while empty");

endmodule

// File: hdl/outputStage.sv
module outputStage (
   input  logic                           clock,
   input  logic                           reset,
   input  logic [arbPkg::portCount - 1:0] grant,
   input  arbPkg::dataWord                headData [arbPkg::portCount],
   input  logic                           outCredit,
   output logic                           holdArbitration,
   output logic                           outValid,
   output arbPkg::dataWord                outData,
   output arbPkg::portIndex               outPort
);
   import arbPkg::*;

   typedef logic [$clog2(creditMax + 1) - 1:0] creditType;

   creditType creditCount;
   logic      granted;
   dataWord   selData;
   portIndex  selPort;

   assign granted = |grant;

   // Freeze arbitration with no downstream credit left
   assign holdArbitration = (creditCount == '0);

   // One-hot mux of queue heads
   // Grant index encoded into the source port number
   always_comb begin
      selData = '0;
      selPort = '0;
      for (int p = 0; p < portCount; p++) begin
         if (grant[p]) begin
            selData = selData | headData[p];
            selPort = selPort | portIndex'(p);
         end
      end
   end

   // Valid follows the grant by one cycle
   always_ff @(posedge clock or negedge reset) begin
      if (!reset) begin
         outValid <= 1'b0;
      end
      else begin
         outValid <= granted;
      end
   end

   // Word and tag, loaded only in granting cycles
   always_ff @(posedge clock) begin
      if (granted) begin
         outData <= selData;
         outPort <= selPort;
      end
   end

   // Downstream credit counter
   // One spent per grant, one back per outCredit pulse
   always_ff @(posedge clock or negedge reset) begin
      if (!reset) begin
         creditCount <= creditType'(creditMax);
      end
      else begin
         case ({granted, outCredit})
            2'b10:   creditCount <= creditCount - 1'b1;
            2'b01:   creditCount <= creditCount + 1'b1;
            // Spend and return together cancel
            default: creditCount <= creditCount;
         endcase
      end
   end

   // Downstream never returns more than it was given
   creditCeiling: assert property (
      @(posedge clock) disable iff (!reset)
      creditCount <= creditMax
   ) else $error("outputStage: credit count %0d above ceiling", creditCount);

   // Arbiter honours the hold
   noGrantOnHold: assert property (
      @(posedge clock) disable iff (!reset)
      holdArbitration |-> !granted
   ) else $error("outputStage: grant %b while out of credit", grant);

endmodule

// File: hdl/roundRobinArbiter.sv
module roundRobinArbiter (
   input  logic       clock,
   input  logic       reset,
   input  logic       holdArbitration,
   input  logic [3:0] req,
   output logic [3:0] grant
);

   logic [3:0] reqValid;
   logic [3:0] previousGrant;

   // Search order of port numbers, highest priority first
   logic [1:0] searchOrder [4];

   // Hold masks every request
   assign reqValid = holdArbitration ? 4'b0000 : req;

   // Rotation by last winner
   // Search starts one below the last winner, winner itself comes last
   always_comb begin
      case (previousGrant)
         4'b1000: begin
            searchOrder = '{2'd2, 2'd1, 2'd0, 2'd3};
         end
         4'b0100: begin
            searchOrder = '{2'd1, 2'd0, 2'd3, 2'd2};
         end
         4'b0010: begin
            searchOrder = '{2'd0, 2'd3, 2'd2, 2'd1};
         end
         // No grant yet, or port 0 last
         default: begin
            searchOrder = '{2'd3, 2'd2, 2'd1, 2'd0};
         end
      endcase
   end

   // Priority pick
   // Walk from lowest to highest priority so the best match is written last
   always_comb begin
      grant = 4'b0000;
      for (int i = 3; i >= 0; i--) begin
         if (reqValid[searchOrder[i]]) begin
            grant = 4'b0001 << searchOrder[i];
         end
      end
   end

   // Last winner only moves on a real grant
   always_ff @(posedge clock or negedge reset) begin
      if (!reset) begin
         previousGrant <= 4'b0000;
      end
      else if (grant != 4'b0000) begin
         previousGrant <= grant;
      end
   end

   // Some requester wins unless held
   // The last winner yields whenever another port requests
   grantFair: assert property (
      @(posedge clock) disable iff (!reset)
      (reqValid == 4'b0000 || $onehot(grant)) &&
      ((reqValid & ~previousGrant) == 4'b0000 || (grant & previousGrant) == 4'b0000)
   ) else $error("roundRobinArbiter: unfair grant %b for req %b", grant, req);

endmodule

// File: runSim.sh
#!/bin/sh
# Build and run the arbMux testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
   --top-module arbMuxTb \
   --Mdir obj_dir \
   -f arbMux.f

simOut=$(./obj_dir/VarbMuxTb)
printf '%s\n' "$simOut"

if printf '%s\n' "$simOut" | grep -qx "TB PASSED"; then
   exit 0
else
   exit 1
fi
